//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_exec_top
RTL_TOP    ?= exec_top
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= ALL TESTS PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- alu.sv
module alu (
    input  logic                          i_exec,
    input  mips_pkg::id_ex_t              i_bundle,
    output logic                          o_wb_we,
    output logic [mips_pkg::NB_REGS-1:0]  o_wb_dir,
    output logic [mips_pkg::NB-1:0]       o_wb_data,
    output logic                          o_retire
);
    import mips_pkg::*;

    logic [NB-1:0] a;
    logic [NB-1:0] b;
    logic [NB-1:0] result;

    assign a = i_bundle.data_a;
    assign b = i_bundle.alu_src ? i_bundle.extension_result : i_bundle.data_b;

    always_comb begin
        case (i_bundle.alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLT:  result = {{(NB-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(NB-1){1'b0}}, a < b};
            // Shifts work on rt
            ALU_SLL:  result = i_bundle.data_b << i_bundle.shamt;
            ALU_SRL:  result = i_bundle.data_b >> i_bundle.shamt;
            ALU_SRA:  result = NB'($signed(i_bundle.data_b) >>> i_bundle.shamt);
            ALU_LUI:  result = b << NB_IMM;
            default:  result = '0;
        endcase
    end

    assign o_wb_we   = i_exec && i_bundle.reg_write;
    assign o_wb_dir  = i_bundle.reg_dir_to_write;
    assign o_wb_data = result;
    assign o_retire  = i_exec;  // Unknown words retire too

endmodule

//--- exec_top.sv
module exec_top (
    input  logic               i_clk,
    input  logic               i_reset,
    input  mips_pkg::wb_m2s_t  i_wb,
    output mips_pkg::wb_s2m_t  o_wb
);
    import mips_pkg::*;

    logic [NB-1:0]       instr;
    logic                step;
    logic                exec;
    logic                busy;
    logic                host_we;
    logic [NB_REGS-1:0]  host_dir;
    logic [NB-1:0]       host_wdata;
    logic [NB-1:0]       host_rdata;
    logic                clr_retired;
    logic                clr_busy;
    logic [NB-1:0]       retired;
    logic [NB-1:0]       busy_cycles;
    logic [NB_REGS-1:0]  rs_dir;
    logic [NB_REGS-1:0]  rt_dir;
    logic [NB-1:0]       rs_data;
    logic [NB-1:0]       rt_data;
    id_ex_t              dec_bundle;
    id_ex_t              ex_bundle;
    logic                wb_we;
    logic [NB_REGS-1:0]  wb_dir;
    logic [NB-1:0]       wb_data;
    logic                retire;

    step_controller u_ctrl (
        .i_clk(i_clk), .i_reset(i_reset), .i_wb(i_wb), .o_wb(o_wb),
        .i_reg_rdata(host_rdata), .i_retired(retired), .i_busy_cycles(busy_cycles),
        .o_instr(instr), .o_step(step), .o_exec(exec), .o_busy(busy),
        .o_host_we(host_we), .o_host_dir(host_dir), .o_host_data(host_wdata),
        .o_clr_retired(clr_retired), .o_clr_busy(clr_busy)
    );

    perf_counter u_perf (
        .i_clk(i_clk), .i_reset(i_reset), .i_retire(retire), .i_busy(busy),
        .i_clr_retired(clr_retired), .i_clr_busy(clr_busy),
        .o_retired(retired), .o_busy_cycles(busy_cycles)
    );

    register_file u_regs (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_rs_dir(rs_dir), .i_rt_dir(rt_dir), .i_host_dir(host_dir),
        .o_rs_data(rs_data), .o_rt_data(rt_data), .o_host_data(host_rdata),
        .i_wb_we(wb_we), .i_wb_dir(wb_dir), .i_wb_data(wb_data),
        .i_host_we(host_we), .i_host_wdir(host_dir), .i_host_wdata(host_wdata)
    );

    instruction_decoder u_dec (
        .i_instr(instr), .o_rs_dir(rs_dir), .o_rt_dir(rt_dir),
        .i_rs_data(rs_data), .i_rt_data(rt_data), .o_bundle(dec_bundle)
    );

    id_ex u_id_ex (
        .i_clk(i_clk), .i_reset(i_reset), .i_step(step),
        .i_bundle(dec_bundle), .o_bundle(ex_bundle)
    );

    alu u_alu (
        .i_exec(exec), .i_bundle(ex_bundle), .o_wb_we(wb_we),
        .o_wb_dir(wb_dir), .o_wb_data(wb_data), .o_retire(retire)
    );

endmodule

//--- id_ex.sv
module id_ex (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_step,
    input  mips_pkg::id_ex_t  i_bundle,
    output mips_pkg::id_ex_t  o_bundle
);

    // Holds between steps
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_bundle <= '0;
        end else if (i_step) begin
            o_bundle <= i_bundle;
        end
    end

    // Out of reset a registered write never targets register 0
    a_no_write_to_r0: assert property (@(posedge i_clk) disable iff (i_reset)
        o_bundle.reg_write |-> (o_bundle.reg_dir_to_write != '0));

endmodule

//--- instruction_decoder.sv
module instruction_decoder (
    input  logic [mips_pkg::NB-1:0]       i_instr,
    output logic [mips_pkg::NB_REGS-1:0]  o_rs_dir,
    output logic [mips_pkg::NB_REGS-1:0]  o_rt_dir,
    input  logic [mips_pkg::NB-1:0]       i_rs_data,
    input  logic [mips_pkg::NB-1:0]       i_rt_data,
    output mips_pkg::id_ex_t              o_bundle
);
    import mips_pkg::*;

    opcode_e              opcode;
    funct_e               funct;
    logic [NB_REGS-1:0]   rd;
    logic [NB_IMM-1:0]    imm;
    alu_op_e              alu_op;
    logic                 is_rtype;
    logic                 sign_ext;
    logic [NB_REGS-1:0]   dest;

    assign opcode   = opcode_e'(i_instr[31:26]);
    assign funct    = funct_e'(i_instr[5:0]);
    assign o_rs_dir = i_instr[25:21];
    assign o_rt_dir = i_instr[20:16];
    assign rd       = i_instr[15:11];
    assign imm      = i_instr[NB_IMM-1:0];

    assign is_rtype = (opcode == OP_SPECIAL);
    assign sign_ext = (opcode == OP_ADDIU) || (opcode == OP_SLTI) || (opcode == OP_SLTIU);
    assign dest     = is_rtype ? rd : o_rt_dir;

    always_comb begin
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    default: alu_op = ALU_NONE;
                endcase
            end
            OP_ADDIU: alu_op = ALU_ADD;
            OP_SLTI:  alu_op = ALU_SLT;
            OP_SLTIU: alu_op = ALU_SLTU;  // Sign-extended, compared unsigned
            OP_ANDI:  alu_op = ALU_AND;
            OP_ORI:   alu_op = ALU_OR;
            OP_XORI:  alu_op = ALU_XOR;
            OP_LUI:   alu_op = ALU_LUI;
            default:  alu_op = ALU_NONE;
        endcase
    end

    assign o_bundle.alu_op           = alu_op;
    assign o_bundle.alu_src          = !is_rtype;
    assign o_bundle.data_a           = i_rs_data;
    assign o_bundle.data_b           = i_rt_data;
    assign o_bundle.extension_result = sign_ext ? {{(NB-NB_IMM){imm[NB_IMM-1]}}, imm}
                                                : {{(NB-NB_IMM){1'b0}}, imm};
    assign o_bundle.shamt            = i_instr[10:6];
    assign o_bundle.reg_write        = (alu_op != ALU_NONE) && (dest != '0);
    assign o_bundle.reg_dir_to_write = dest;

endmodule

//--- mips_pkg.sv
package mips_pkg;

    localparam int NB        = 32;
    localparam int NB_OPCODE = 6;
    localparam int NB_FCODE  = 6;
    localparam int NB_REGS   = 5;
    localparam int NB_SHAMT  = 5;
    localparam int NB_IMM    = 16;
    localparam int N_REGS    = 2 ** NB_REGS;
    localparam int NB_WB_ADR = 6;

    // Word addresses 0 to 31 map onto the register file
    localparam logic [NB_WB_ADR-1:0] ADR_INSTR       = 6'd32;  // Write only
    localparam logic [NB_WB_ADR-1:0] ADR_RETIRED     = 6'd33;  // Write clears
    localparam logic [NB_WB_ADR-1:0] ADR_BUSY_CYCLES = 6'd34;  // Write clears
    localparam logic [NB_WB_ADR-1:0] ADR_STATUS      = 6'd35;  // Bit 0 busy

    typedef enum logic [NB_OPCODE-1:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    typedef enum logic [NB_FCODE-1:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_NONE
    } alu_op_e;

    typedef struct packed {
        alu_op_e               alu_op;
        logic                  alu_src;           // 0 data_b, 1 immediate
        logic [NB-1:0]         data_a;
        logic [NB-1:0]         data_b;
        logic [NB-1:0]         extension_result;
        logic [NB_SHAMT-1:0]   shamt;
        logic                  reg_write;
        logic [NB_REGS-1:0]    reg_dir_to_write;
    } id_ex_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [NB_WB_ADR-1:0]  adr;
        logic [NB-1:0]         dat;
    } wb_m2s_t;

    typedef struct packed {
        logic                  ack;
        logic [NB-1:0]         dat;
    } wb_s2m_t;

endpackage

//--- perf_counter.sv
module perf_counter (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_retire,
    input  logic                     i_busy,
    input  logic                     i_clr_retired,
    input  logic                     i_clr_busy,
    output logic [mips_pkg::NB-1:0]  o_retired,
    output logic [mips_pkg::NB-1:0]  o_busy_cycles
);
    import mips_pkg::*;

    // Both counters wrap; clear wins over increment
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_retired     <= '0;
            o_busy_cycles <= '0;
        end else begin
            if (i_clr_retired) begin
                o_retired <= '0;
            end else if (i_retire) begin
                o_retired <= o_retired + NB'(1);
            end

            if (i_clr_busy) begin
                o_busy_cycles <= '0;
            end else if (i_busy) begin
                o_busy_cycles <= o_busy_cycles + NB'(1);
            end
        end
    end

endmodule

//--- project.f
mips_pkg.sv
step_controller.sv
perf_counter.sv
register_file.sv
instruction_decoder.sv
id_ex.sv
alu.sv
exec_top.sv
tb_exec_top.sv

//--- register_file.sv
module register_file (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic [mips_pkg::NB_REGS-1:0]  i_rs_dir,
    input  logic [mips_pkg::NB_REGS-1:0]  i_rt_dir,
    input  logic [mips_pkg::NB_REGS-1:0]  i_host_dir,
    output logic [mips_pkg::NB-1:0]       o_rs_data,
    output logic [mips_pkg::NB-1:0]       o_rt_data,
    output logic [mips_pkg::NB-1:0]       o_host_data,
    input  logic                          i_wb_we,
    input  logic [mips_pkg::NB_REGS-1:0]  i_wb_dir,
    input  logic [mips_pkg::NB-1:0]       i_wb_data,
    input  logic                          i_host_we,
    input  logic [mips_pkg::NB_REGS-1:0]  i_host_wdir,
    input  logic [mips_pkg::NB-1:0]       i_host_wdata
);
    import mips_pkg::*;

    logic [NB-1:0] regs [N_REGS];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_we && (i_wb_dir != '0)) begin
            regs[i_wb_dir] <= i_wb_data;
        end else if (i_host_we && (i_host_wdir != '0)) begin
            regs[i_host_wdir] <= i_host_wdata;
        end
    end

    // Register 0 always reads zero
    assign o_rs_data   = (i_rs_dir == '0) ? '0 : regs[i_rs_dir];
    assign o_rt_data   = (i_rt_dir == '0) ? '0 : regs[i_rt_dir];
    assign o_host_data = (i_host_dir == '0) ? '0 : regs[i_host_dir];

    // Writeback and host access are serialized by the controller
    a_one_writer: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_wb_we && i_host_we));

endmodule

//--- step_controller.sv
module step_controller (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  mips_pkg::wb_m2s_t             i_wb,
    output mips_pkg::wb_s2m_t             o_wb,
    input  logic [mips_pkg::NB-1:0]       i_reg_rdata,
    input  logic [mips_pkg::NB-1:0]       i_retired,
    input  logic [mips_pkg::NB-1:0]       i_busy_cycles,
    output logic [mips_pkg::NB-1:0]       o_instr,
    output logic                          o_step,
    output logic                          o_exec,
    output logic                          o_busy,
    output logic                          o_host_we,
    output logic [mips_pkg::NB_REGS-1:0]  o_host_dir,
    output logic [mips_pkg::NB-1:0]       o_host_data,
    output logic                          o_clr_retired,
    output logic                          o_clr_busy
);
    import mips_pkg::*;

    typedef enum logic [1:0] {IDLE, DECODE, EXECUTE, ACK} state_e;

    state_e         state;
    logic           req;
    logic           is_reg;
    logic           issue;
    logic [NB-1:0]  rd_mux;
    logic [NB-1:0]  rdata;

    assign req    = (state == IDLE) && i_wb.cyc && i_wb.stb;  // Only taken when idle
    assign is_reg = (i_wb.adr < ADR_INSTR);
    assign issue  = req && i_wb.we && (i_wb.adr == ADR_INSTR);

    always_comb begin
        if (is_reg) begin
            rd_mux = i_reg_rdata;
        end else begin
            case (i_wb.adr)
                ADR_RETIRED:     rd_mux = i_retired;
                ADR_BUSY_CYCLES: rd_mux = i_busy_cycles;
                ADR_STATUS:      rd_mux = {{(NB-1){1'b0}}, o_busy};
                default:         rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (req) state <= issue ? DECODE : ACK;
                DECODE:  state <= EXECUTE;
                EXECUTE: state <= ACK;   // Ack held back until writeback
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (req) rdata <= rd_mux;
        if (issue) o_instr <= i_wb.dat;
    end

    assign o_wb.ack = (state == ACK);
    assign o_wb.dat = rdata;

    assign o_step = (state == DECODE);
    assign o_exec = (state == EXECUTE);
    assign o_busy = o_step || o_exec;

    assign o_host_we     = req && i_wb.we && is_reg;
    assign o_host_dir    = i_wb.adr[NB_REGS-1:0];
    assign o_host_data   = i_wb.dat;
    assign o_clr_retired = req && i_wb.we && (i_wb.adr == ADR_RETIRED);
    assign o_clr_busy    = req && i_wb.we && (i_wb.adr == ADR_BUSY_CYCLES);

    // Host must still hold the cycle when the ack arrives
    a_ack_in_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        o_wb.ack |-> (i_wb.cyc && i_wb.stb));

    a_step_then_exec: assert property (@(posedge i_clk) disable iff (i_reset)
        o_step |-> !o_exec ##1 (o_exec && !o_step));

endmodule

//--- tb_exec_top.sv
module tb_exec_top;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    localparam int R_TRIALS = 6;
    localparam int N_RANDOM = 200;
    // Bus accesses of all phases, with some slack
    localparam int N_OPS = 35 + 64 + 11 * R_TRIALS * 4 + 7 * 6 * 7 * 3 + N_RANDOM * 2 + 200;

    localparam logic [5:0] R_FUNCTS [11] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
        FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
    localparam logic [5:0] I_OPS [7] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
        OP_XORI, OP_LUI};
    localparam logic [15:0] IMM_EDGES [6] = '{16'h0000, 16'h0001, 16'h7fff, 16'h8000,
        16'hfffe, 16'hffff};
    localparam logic [31:0] RS_EDGES [7] = '{32'h0000_0000, 32'h7fff_ffff, 32'h8000_0000,
        32'hffff_ffff, 32'hffff_8000, 32'h0000_7fff, 32'h0000_8000};

    typedef struct packed {
        logic [NB_WB_ADR-1:0]  adr;
        logic [NB-1:0]         exp;
        logic [NB-1:0]         got;
    } check_t;

    logic           clk;
    logic           reset;
    wb_m2s_t        wb_in;
    wb_s2m_t        wb_out;
    integer         seed = 91021;
    logic [NB-1:0]  shadow [N_REGS];
    logic [NB-1:0]  shadow_retired;
    logic [NB-1:0]  shadow_busy;
    check_t         check_q [$];
    int             n_queued = 0;
    int             n_checked = 0;

    exec_top DUT (.i_clk(clk), .i_reset(reset), .i_wb(wb_in), .o_wb(wb_out));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    // Expected result from the MIPS encoding rules
    function automatic logic [NB-1:0] exec_ref(input logic [NB-1:0] instr,
            input logic [NB-1:0] rs_val, input logic [NB-1:0] rt_val,
            output logic wr, output logic [NB_REGS-1:0] dst);
        logic [NB-1:0]        simm;
        logic [NB-1:0]        zimm;
        logic [NB_SHAMT-1:0]  sh;
        logic [NB-1:0]        res;
        simm = {{16{instr[15]}}, instr[15:0]};
        zimm = {16'h0000, instr[15:0]};
        sh   = instr[10:6];
        res  = '0;
        wr   = 1'b1;
        dst  = instr[20:16];
        case (instr[31:26])
            OP_SPECIAL: begin
                dst = instr[15:11];
                case (instr[5:0])
                    FN_ADDU: res = rs_val + rt_val;
                    FN_SUBU: res = rs_val - rt_val;
                    FN_AND:  res = rs_val & rt_val;
                    FN_OR:   res = rs_val | rt_val;
                    FN_XOR:  res = rs_val ^ rt_val;
                    FN_NOR:  res = ~(rs_val | rt_val);
                    FN_SLT:  res = {31'b0, $signed(rs_val) < $signed(rt_val)};
                    FN_SLTU: res = {31'b0, rs_val < rt_val};
                    FN_SLL:  res = rt_val << sh;
                    FN_SRL:  res = rt_val >> sh;
                    FN_SRA:  res = $unsigned($signed(rt_val) >>> sh);
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: res = rs_val + simm;
            OP_SLTI:  res = {31'b0, $signed(rs_val) < $signed(simm)};
            OP_SLTIU: res = {31'b0, rs_val < simm};  // Sign-extended, unsigned compare
            OP_ANDI:  res = rs_val & zimm;
            OP_ORI:   res = rs_val | zimm;
            OP_XORI:  res = rs_val ^ zimm;
            OP_LUI:   res = {instr[15:0], 16'h0000};
            default:  wr = 1'b0;
        endcase
        if (dst == '0) wr = 1'b0;
        return res;
    endfunction

    function automatic int rand_reg();
        return 1 + int'({$random(seed)} % 31);
    endfunction

    // Starts and ends 1 ns after a rising edge
    task automatic bus_cycle(input logic we, input logic [NB_WB_ADR-1:0] adr,
            input logic [NB-1:0] wdat, output logic [NB-1:0] rdat);
        wb_in.cyc = 1'b1;
        wb_in.stb = 1'b1;
        wb_in.we  = we;
        wb_in.adr = adr;
        wb_in.dat = wdat;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_out.ack);
        rdat = wb_out.dat;
        @(posedge clk);  // Held through the ack edge
        #1;
        wb_in = '0;
    endtask

    task automatic wb_write(input logic [NB_WB_ADR-1:0] adr, input logic [NB-1:0] dat);
        logic [NB-1:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [NB_WB_ADR-1:0] adr, input logic [NB-1:0] exp);
        check_t c;
        c.adr = adr;
        c.exp = exp;
        bus_cycle(1'b0, adr, '0, c.got);
        check_q.push_back(c);
        n_queued++;
    endtask

    task automatic set_reg(input int r, input logic [NB-1:0] val);
        wb_write(NB_WB_ADR'(r), val);
        if (r != 0) shadow[NB_REGS'(r)] = val;
    endtask

    task automatic check_reg(input int r);
        wb_read(NB_WB_ADR'(r), shadow[NB_REGS'(r)]);
    endtask

    task automatic check_counters();
        wb_read(ADR_RETIRED, shadow_retired);
        wb_read(ADR_BUSY_CYCLES, shadow_busy);
    endtask

    task automatic issue(input logic [NB-1:0] instr);
        logic [NB-1:0]       res;
        logic                wr;
        logic [NB_REGS-1:0]  dst;
        res = exec_ref(instr, shadow[instr[25:21]], shadow[instr[20:16]], wr, dst);
        wb_write(ADR_INSTR, instr);
        if (wr) shadow[dst] = res;
        shadow_retired = shadow_retired + 32'd1;
        shadow_busy    = shadow_busy + 32'd2;  // DECODE and EXECUTE
    endtask

    initial begin : compare
        check_t c;
        forever begin
            @(negedge clk);
            while (check_q.size() > 0) begin
                c = check_q.pop_front();
                n_checked++;
                assert (c.got === c.exp) else begin
                    $display("error: time %0t adr %0d read %08h expected %08h",
                        $time, c.adr, c.got, c.exp);
                    stop_on_failure();
                end
            end
        end
    end

    initial begin : watchdog
        repeat (N_OPS * 20 + 1000) @(posedge clk);
        $display("Watchdog expired, the DUT stopped acknowledging bus accesses");
        stop_on_failure();
    end

    initial begin : main
        logic [NB-1:0] word;
        int rs;
        int rt;
        int sel;
        wb_in          = '0;
        reset          = 1'b1;
        shadow_retired = '0;
        shadow_busy    = '0;
        for (int r = 0; r < N_REGS; r++) shadow[r] = '0;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        for (int r = 0; r < N_REGS; r++) check_reg(r);
        check_counters();
        wb_read(ADR_STATUS, '0);

        for (int r = 0; r < N_REGS; r++) set_reg(r, $random(seed));
        for (int r = 0; r < N_REGS; r++) check_reg(r);

        for (int f = 0; f < 11; f++) begin
            for (int t = 0; t < R_TRIALS; t++) begin
                rs = rand_reg();
                rt = rand_reg();
                set_reg(rs, $random(seed));
                set_reg(rt, $random(seed));
                word = $random(seed);  // Shamt from bits 10:6
                word = {6'h00, 5'(rs), 5'(rt), 5'(rand_reg()), word[10:6], R_FUNCTS[4'(f)]};
                issue(word);
                check_reg(int'(word[15:11]));
            end
        end

        // Every immediate edge against every rs edge
        for (int k = 0; k < 7; k++) begin
            for (int i = 0; i < 6; i++) begin
                for (int j = 0; j < 7; j++) begin
                    rs = rand_reg();
                    rt = rand_reg();
                    set_reg(rs, RS_EDGES[3'(j)]);
                    issue({I_OPS[3'(k)], 5'(rs), 5'(rt), IMM_EDGES[3'(i)]});
                    check_reg(rt);
                end
            end
        end

        for (int r = 1; r < N_REGS; r++) set_reg(r, $random(seed));
        check_counters();
        wb_write(ADR_RETIRED, '0);
        wb_write(ADR_BUSY_CYCLES, '0);
        shadow_retired = '0;
        shadow_busy    = '0;
        for (int n = 0; n < N_RANDOM; n++) begin
            word = $random(seed);
            sel  = int'({$random(seed)} % 4);  // 0 keeps the raw word
            if (sel == 1 || sel == 3) begin
                word[31:26] = OP_SPECIAL;
                word[5:0]   = R_FUNCTS[4'({$random(seed)} % 11)];
            end else if (sel == 2) begin
                word[31:26] = I_OPS[3'({$random(seed)} % 7)];
            end
            if (sel == 3) word[15:11] = '0;
            issue(word);
        end
        wb_read(ADR_RETIRED, 32'(N_RANDOM));
        wb_read(ADR_BUSY_CYCLES, 32'(2 * N_RANDOM));
        for (int r = 0; r < N_REGS; r++) check_reg(r);

        wb_write(ADR_RETIRED, '0);
        shadow_retired = '0;
        check_counters();  // Busy count survives
        for (int n = 0; n < 3; n++) begin
            issue({6'h00, 5'(rand_reg()), 5'(rand_reg()), 5'(rand_reg()), 5'h00, FN_ADDU});
        end
        wb_write(ADR_BUSY_CYCLES, '0);
        shadow_busy = '0;
        check_counters();
        for (int r = 0; r < N_REGS; r++) check_reg(r);

        repeat (2) @(posedge clk);
        if (n_checked == n_queued) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("Only %0d of %0d reads reached the compare process", n_checked, n_queued);
            stop_on_failure();
        end
    end

endmodule
